//--- verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

        // ------------------------------
        // Widths and machine words
        // ------------------------------
        localparam int WORD_WIDTH    = 32;
        localparam int REG_IDX_WIDTH = 5;

        typedef logic [WORD_WIDTH-1:0]    word_t;
        typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

        localparam word_t RESET_VECTOR = 32'hBFC00000;     // First fetch address.

        // ------------------------------
        // Instruction encodings
        // ------------------------------
        typedef enum logic [5:0] {
                OP_SPECIAL = 6'h00,
                OP_REGIMM  = 6'h01,
                OP_J       = 6'h02,
                OP_BEQ     = 6'h04,
                OP_BNE     = 6'h05,
                OP_ADDIU   = 6'h09,
                OP_SLTI    = 6'h0A,
                OP_ANDI    = 6'h0C,
                OP_ORI     = 6'h0D,
                OP_XORI    = 6'h0E,
                OP_LUI     = 6'h0F,
                OP_LW      = 6'h23,
                OP_SW      = 6'h2B
        } opcode_t;

        typedef enum logic [5:0] {
                FN_SLL  = 6'h00,
                FN_SRL  = 6'h02,
                FN_JR   = 6'h08,
                FN_ADDU = 6'h21,
                FN_SUBU = 6'h23,
                FN_AND  = 6'h24,
                FN_OR   = 6'h25,
                FN_XOR  = 6'h26,
                FN_SLT  = 6'h2A,
                FN_SLTU = 6'h2B
        } funct_t;

        typedef enum logic [3:0] {
                ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
        } alu_op_t;

        typedef enum logic [2:0] {
                BR_NONE, BR_EQ, BR_NE, BR_GEZ, BR_LTZ, BR_JUMP, BR_JUMP_REG
        } branch_t;

endpackage

`default_nettype wire

//--- verilog/mips_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module mips_decoder (
        input  mips_pkg::word_t    instr,
        output mips_pkg::reg_idx_t rs,
        output mips_pkg::reg_idx_t rt,
        output mips_pkg::reg_idx_t rd_dest,
        output mips_pkg::word_t    imm,
        output mips_pkg::alu_op_t  alu_op,
        output logic               alu_use_imm,
        output logic               reg_write,
        output logic               mem_read,
        output logic               mem_write,
        output mips_pkg::branch_t  branch,
        output logic [4:0]         shamt
);
        import mips_pkg::*;

        opcode_t opcode;
        funct_t  funct;

        assign opcode = opcode_t'(instr[31:26]);
        assign funct  = funct_t'(instr[5:0]);
        assign rs     = instr[25:21];
        assign rt     = instr[20:16];
        assign shamt  = instr[10:6];

        always_comb begin
                imm         = {{16{instr[15]}}, instr[15:0]};
                rd_dest     = instr[20:16];     // I-type writes rt.
                alu_op      = ALU_ADD;
                alu_use_imm = 1'b1;
                reg_write   = 1'b0;
                mem_read    = 1'b0;
                mem_write   = 1'b0;
                branch      = BR_NONE;
                case (opcode)
                OP_SPECIAL: begin
                        rd_dest     = instr[15:11];
                        alu_use_imm = 1'b0;
                        reg_write   = 1'b1;
                        case (funct)
                        FN_SLL:  alu_op = ALU_SLL;
                        FN_SRL:  alu_op = ALU_SRL;
                        FN_ADDU: alu_op = ALU_ADD;
                        FN_SUBU: alu_op = ALU_SUB;
                        FN_AND:  alu_op = ALU_AND;
                        FN_OR:   alu_op = ALU_OR;
                        FN_XOR:  alu_op = ALU_XOR;
                        FN_SLT:  alu_op = ALU_SLT;
                        FN_SLTU: alu_op = ALU_SLTU;
                        FN_JR: begin
                                reg_write = 1'b0;
                                branch    = BR_JUMP_REG;
                        end
                        default: reg_write = 1'b0;      // Unsupported funct is a nop.
                        endcase
                end
                OP_REGIMM: begin
                        if (instr[20:16] == 5'd1)
                                branch = BR_GEZ;
                        else if (instr[20:16] == 5'd0)
                                branch = BR_LTZ;
                end
                OP_J: branch = BR_JUMP;
                OP_BEQ, OP_BNE: begin
                        alu_use_imm = 1'b0;
                        alu_op      = ALU_SUB;  // Zero flag compares rs and rt.
                        branch      = (opcode == OP_BEQ) ? BR_EQ : BR_NE;
                end
                OP_ADDIU: reg_write = 1'b1;
                OP_SLTI: begin
                        alu_op    = ALU_SLT;
                        reg_write = 1'b1;
                end
                OP_ANDI, OP_ORI, OP_XORI: begin
                        imm       = {16'h0000, instr[15:0]};
                        reg_write = 1'b1;
                        alu_op    = (opcode == OP_ANDI) ? ALU_AND :
                                    (opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
                end
                OP_LUI: begin
                        alu_op    = ALU_LUI;
                        reg_write = 1'b1;
                end
                OP_LW: begin
                        mem_read  = 1'b1;
                        reg_write = 1'b1;
                end
                OP_SW: mem_write = 1'b1;
                default: ;
                endcase
        end

endmodule

`default_nettype wire

//--- verilog/mips_alu.sv
`timescale 1ns/1ns
`default_nettype none

module mips_alu (
        input  mips_pkg::alu_op_t op,
        input  mips_pkg::word_t   a,
        input  mips_pkg::word_t   b,
        input  logic [4:0]        shamt,
        output mips_pkg::word_t   result,
        output logic              zero
);
        import mips_pkg::*;

        logic lt_signed;
        logic lt_unsigned;

        assign lt_signed   = $signed(a) < $signed(b);
        assign lt_unsigned = a < b;

        always_comb begin
                case (op)
                ALU_ADD:  result = a + b;       // Wraps without an overflow trap.
                ALU_SUB:  result = a - b;
                ALU_AND:  result = a & b;
                ALU_OR:   result = a | b;
                ALU_XOR:  result = a ^ b;
                ALU_SLT:  result = {{(WORD_WIDTH-1){1'b0}}, lt_signed};
                ALU_SLTU: result = {{(WORD_WIDTH-1){1'b0}}, lt_unsigned};
                ALU_SLL:  result = b << shamt;
                ALU_SRL:  result = b >> shamt;
                ALU_LUI:  result = {b[15:0], 16'h0000};
                default:  result = '0;
                endcase
        end

        assign zero = (result == '0);   // Used by beq and bne.

endmodule

`default_nettype wire

//--- verilog/mips_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module mips_regfile (
        input  logic               clk,
        input  logic               rst_n,
        input  logic               enable,
        input  mips_pkg::reg_idx_t rs,
        input  mips_pkg::reg_idx_t rt,
        input  mips_pkg::reg_idx_t rd,
        input  logic               write,
        input  mips_pkg::word_t    wdata,
        output mips_pkg::word_t    rs_data,
        output mips_pkg::word_t    rt_data,
        output mips_pkg::word_t    v0
);
        import mips_pkg::*;

        word_t regs [1:31];     // $0 has no storage.

        always_ff @(posedge clk) begin
                if (rst_n && enable && write && rd != '0) begin
                        regs[rd] <= wdata;
                end
        end

        assign rs_data = (rs == '0) ? '0 : regs[rs];
        assign rt_data = (rt == '0) ? '0 : regs[rt];
        assign v0      = regs[2];

endmodule

`default_nettype wire

//--- verilog/mips_cpu_harvard.sv
`timescale 1ns/1ns
`default_nettype none

module mips_cpu_harvard #(
        parameter mips_pkg::word_t RESET_PC = mips_pkg::RESET_VECTOR
) (
        input  logic            clk,
        input  logic            rst_n,
        input  logic            clk_enable,
        output logic            active,
        output mips_pkg::word_t register_v0,
        output mips_pkg::word_t instr_address,
        input  mips_pkg::word_t instr_readdata,
        output mips_pkg::word_t data_address,
        output logic            data_write,
        output logic            data_read,
        output mips_pkg::word_t data_writedata,
        input  mips_pkg::word_t data_readdata
);
        import mips_pkg::*;

        word_t    pc;
        word_t    next_pc;             // Delay slot address.
        reg_idx_t rs, rt, rd_dest;
        word_t    imm;
        alu_op_t  alu_op;
        logic     alu_use_imm, reg_write, mem_read, mem_write;
        branch_t  branch;
        logic [4:0] shamt;
        word_t    rs_data, rt_data, alu_b, alu_result, wb_data;
        word_t    branch_target, jump_target, following_pc;
        logic     alu_zero, taken, execute;

        assign execute = clk_enable && active;

        mips_decoder u_decoder (
                .instr       (instr_readdata),
                .rs          (rs),
                .rt          (rt),
                .rd_dest     (rd_dest),
                .imm         (imm),
                .alu_op      (alu_op),
                .alu_use_imm (alu_use_imm),
                .reg_write   (reg_write),
                .mem_read    (mem_read),
                .mem_write   (mem_write),
                .branch      (branch),
                .shamt       (shamt)
        );

        mips_regfile u_regfile (
                .clk     (clk),
                .rst_n   (rst_n),
                .enable  (execute),
                .rs      (rs),
                .rt      (rt),
                .rd      (rd_dest),
                .write   (reg_write),
                .wdata   (wb_data),
                .rs_data (rs_data),
                .rt_data (rt_data),
                .v0      (register_v0)
        );

        assign alu_b = alu_use_imm ? imm : rt_data;

        mips_alu u_alu (
                .op     (alu_op),
                .a      (rs_data),
                .b      (alu_b),
                .shamt  (shamt),
                .result (alu_result),
                .zero   (alu_zero)
        );

        // ------------------------------
        // Memory port and write-back
        // ------------------------------
        assign instr_address  = pc;
        assign data_address   = alu_result;
        assign data_writedata = rt_data;
        assign data_write     = mem_write && active && rst_n;
        assign data_read      = mem_read && active && rst_n;
        assign wb_data        = mem_read ? data_readdata : alu_result;

        // ------------------------------
        // Branch resolution
        // ------------------------------
        assign branch_target = next_pc + {imm[WORD_WIDTH-3:0], 2'b00};
        assign jump_target   = {next_pc[31:28], instr_readdata[25:0], 2'b00};

        always_comb begin
                case (branch)
                BR_EQ:   taken = alu_zero;
                BR_NE:   taken = !alu_zero;
                BR_GEZ:  taken = !rs_data[WORD_WIDTH-1];
                BR_LTZ:  taken = rs_data[WORD_WIDTH-1];
                default: taken = 1'b0;
                endcase
                if (branch == BR_JUMP)
                        following_pc = jump_target;
                else if (branch == BR_JUMP_REG)
                        following_pc = rs_data;
                else if (taken)
                        following_pc = branch_target;
                else
                        following_pc = next_pc + 32'd4;
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        pc      <= RESET_PC;
                        next_pc <= RESET_PC + 32'd4;
                        active  <= 1'b1;
                end else if (execute) begin
                        pc      <= next_pc;
                        next_pc <= following_pc;
                        if (next_pc == '0) begin
                                active <= 1'b0;         // Halt on fetch of 0.
                        end
                end
        end

endmodule

`default_nettype wire

//--- verilog/data_memory.sv
`timescale 1ns/1ns
`default_nettype none

module data_memory #(
        parameter int DATA_WORDS = 256
) (
        input  logic            clk,
        input  logic            clk_enable,
        input  logic            rst_n,
        input  mips_pkg::word_t address,
        input  mips_pkg::word_t writedata,
        input  logic            write,
        input  logic            read,
        output mips_pkg::word_t readdata
);
        import mips_pkg::*;

        localparam int ADDR_BITS = $clog2(DATA_WORDS);

        word_t                mem [DATA_WORDS];
        logic [ADDR_BITS-1:0] index;

        assign index = address[ADDR_BITS+1:2];  // Wraps modulo depth.

        always_ff @(posedge clk) begin
                if (rst_n && clk_enable && write) begin
                        mem[index] <= writedata;
                end
        end

        assign readdata = read ? mem[index] : '0;

endmodule

`default_nettype wire

//--- verilog/mips_system.sv
`timescale 1ns/1ns
`default_nettype none

module mips_system #(
        parameter int              DATA_WORDS = 256,
        parameter mips_pkg::word_t RESET_PC   = mips_pkg::RESET_VECTOR
) (
        input  logic            clk,
        input  logic            rst_n,
        input  logic            clk_enable,
        output logic            active,
        output mips_pkg::word_t register_v0,
        output mips_pkg::word_t instr_address,
        input  mips_pkg::word_t instr_readdata
);
        import mips_pkg::*;

        word_t data_address, data_writedata, data_readdata;
        logic  data_write, data_read;

        mips_cpu_harvard #(
                .RESET_PC (RESET_PC)
        ) u_cpu (
                .clk            (clk),
                .rst_n          (rst_n),
                .clk_enable     (clk_enable),
                .active         (active),
                .register_v0    (register_v0),
                .instr_address  (instr_address),
                .instr_readdata (instr_readdata),
                .data_address   (data_address),
                .data_write     (data_write),
                .data_read      (data_read),
                .data_writedata (data_writedata),
                .data_readdata  (data_readdata)
        );

        data_memory #(
                .DATA_WORDS (DATA_WORDS)
        ) u_data_memory (
                .clk        (clk),
                .clk_enable (clk_enable),
                .rst_n      (rst_n),
                .address    (data_address),
                .writedata  (data_writedata),
                .write      (data_write),
                .read       (data_read),
                .readdata   (data_readdata)
        );

endmodule

`default_nettype wire

//--- verification/tb_mips_model.svh
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

localparam int DMEM_BITS = $clog2(DATA_WORDS);
localparam int MODEL_STEPS = 1000;

// ------------------------------
// Instruction-set model
// ------------------------------
function automatic word_t model_run();
        word_t                regs [32];
        word_t                dmem [DATA_WORDS];
        word_t                pc, npc, following, ins, a, b, imm_s, addr, wval;
        reg_idx_t             dest;
        logic [DMEM_BITS-1:0] idx;
        logic                 wen, done;
        int                   steps;

        regs = '{default: '0};
        dmem = '{default: '0};
        pc = RESET_VECTOR;
        npc = RESET_VECTOR + 32'd4;
        done = 1'b0;
        steps = 0;
        while (!done && steps < MODEL_STEPS) begin
                ins = rom_word(pc);
                a = regs[ins[25:21]];
                b = regs[ins[20:16]];
                imm_s = {{16{ins[15]}}, ins[15:0]};
                addr = a + imm_s;
                idx = DMEM_BITS'((addr >> 2) % DATA_WORDS);    // Wraps at memory depth.
                following = npc + 32'd4;
                dest = ins[15:11];
                wen = 1'b0;
                wval = '0;
                case (ins[31:26])
                6'h00: begin
                        wen = 1'b1;
                        case (ins[5:0])
                        6'h00: wval = b << ins[10:6];
                        6'h02: wval = b >> ins[10:6];
                        6'h21: wval = a + b;
                        6'h23: wval = a - b;
                        6'h24: wval = a & b;
                        6'h25: wval = a | b;
                        6'h26: wval = a ^ b;
                        6'h2A: wval = {31'b0, $signed(a) < $signed(b)};
                        6'h2B: wval = {31'b0, a < b};
                        6'h08: begin
                                wen = 1'b0;
                                following = a;
                        end
                        default: wen = 1'b0;
                        endcase
                end
                6'h01: begin
                        if (ins[20:16] == 5'd1 && !a[31])
                                following = npc + {imm_s[29:0], 2'b00};
                        else if (ins[20:16] == 5'd0 && a[31])
                                following = npc + {imm_s[29:0], 2'b00};
                end
                6'h02: following = {npc[31:28], ins[25:0], 2'b00};
                6'h04: if (a == b) following = npc + {imm_s[29:0], 2'b00};
                6'h05: if (a != b) following = npc + {imm_s[29:0], 2'b00};
                6'h09: begin
                        dest = ins[20:16];
                        wen = 1'b1;
                        wval = addr;
                end
                6'h0F: begin
                        dest = ins[20:16];
                        wen = 1'b1;
                        wval = {ins[15:0], 16'h0000};
                end
                6'h23: begin
                        dest = ins[20:16];
                        wen = 1'b1;
                        wval = dmem[idx];
                end
                6'h2B: dmem[idx] = b;
                default: ;
                endcase
                if (wen && dest != 5'd0)
                        regs[dest] = wval;
                done = (npc == '0);     // Delay slot of the jump to 0 is the last one.
                pc = npc;
                npc = following;
                steps++;
        end
        if (!done) begin
                $display("Reference model did not halt within %0d steps", MODEL_STEPS);
                check_errors++;
        end
        return regs[2];
endfunction

`endif

//--- verification/tb_mips_system.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mips_system;
        import mips_pkg::*;

        localparam int DATA_WORDS = 256;
        localparam int ROM_WORDS  = 256;
        localparam int MAX_CYCLES = 2000;

        logic  clk = 1'b0;
        logic  rst_n, clk_enable, active, armed, seen;
        word_t register_v0, instr_address, instr_readdata, expected_v0;
        word_t rom [ROM_WORDS];
        int    prog_len = 0;
        int    check_errors = 0;
        int    compare_errors = 0;
        int    halt_count = 0;
        int    cycle_count;
        integer seed = 32'h7cc2_7671;

        mips_system #(
                .DATA_WORDS (DATA_WORDS),
                .RESET_PC   (RESET_VECTOR)
        ) u_mips_system (
                .clk            (clk),
                .rst_n          (rst_n),
                .clk_enable     (clk_enable),
                .active         (active),
                .register_v0    (register_v0),
                .instr_address  (instr_address),
                .instr_readdata (instr_readdata)
        );

        always #10 clk = ~clk;

        // Program ROM returns a NOP outside the loaded image.
        function automatic word_t rom_word(input word_t addr);
                word_t offset;
                offset = addr - RESET_VECTOR;
                if (offset < 32'(prog_len) * 4)
                        return rom[offset[9:2]];
                return '0;
        endfunction

        always_comb instr_readdata = rom_word(instr_address);

        `include "tb_mips_model.svh"

        // ------------------------------
        // Instruction encoding
        // ------------------------------
        function automatic word_t r_type(input funct_t fn, input int rs, rt, rd, sh);
                return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
        endfunction

        function automatic word_t i_type(input opcode_t op, input int rs, rt, imm);
                return {op, 5'(rs), 5'(rt), 16'(imm)};
        endfunction

        function automatic word_t j_type(input int index);
                word_t target;
                target = RESET_VECTOR + 32'(index) * 4;
                return {OP_J, target[27:2]};
        endfunction

        task automatic emit(input word_t w);
                rom[prog_len[7:0]] = w;
                prog_len++;
        endtask

        task automatic emit_halt();
                emit(r_type(FN_JR, 0, 0, 0, 0));
                emit('0);       // Delay slot.
        endtask

        // ------------------------------
        // Test programs
        // ------------------------------
        task automatic build_sign_program();
                prog_len = 0;
                emit(i_type(OP_ADDIU, 0, 2, 0));
                emit(i_type(OP_ADDIU, 0, 3, -5));
                emit(i_type(OP_ADDIU, 0, 4, 7));
                emit(i_type(OP_REGIMM, 3, 0, 2));       // bltz taken.
                emit(i_type(OP_ADDIU, 2, 2, 64));
                emit(i_type(OP_ADDIU, 2, 2, 1000));
                emit(i_type(OP_REGIMM, 3, 1, 6));       // bgez not taken.
                emit(i_type(OP_ADDIU, 2, 2, 32));
                emit(i_type(OP_REGIMM, 4, 1, 2));       // bgez taken.
                emit(i_type(OP_ADDIU, 2, 2, 16));
                emit(i_type(OP_ADDIU, 2, 2, 2000));
                emit(i_type(OP_REGIMM, 4, 0, 1));       // bltz not taken.
                emit(i_type(OP_ADDIU, 2, 2, 16));
                emit_halt();
        endtask

        task automatic build_alu_program();
                prog_len = 0;
                emit(i_type(OP_ADDIU, 0, 8, 'h1234));
                emit(i_type(OP_LUI, 0, 9, 'h8001));
                emit(r_type(FN_ADDU, 8, 9, 10, 0));
                emit(r_type(FN_SUBU, 8, 9, 11, 0));
                emit(r_type(FN_AND, 10, 11, 12, 0));
                emit(r_type(FN_OR, 8, 9, 13, 0));
                emit(r_type(FN_XOR, 10, 13, 14, 0));
                emit(r_type(FN_SLL, 0, 8, 15, 4));
                emit(r_type(FN_SRL, 0, 9, 16, 8));
                emit(i_type(OP_ADDIU, 0, 17, -1));
                emit(r_type(FN_SLT, 17, 8, 18, 0));
                emit(r_type(FN_SLTU, 17, 8, 19, 0));
                emit(r_type(FN_SLTU, 8, 17, 20, 0));
                emit(r_type(FN_ADDU, 10, 11, 2, 0));
                emit(r_type(FN_XOR, 2, 12, 2, 0));
                emit(r_type(FN_ADDU, 2, 13, 2, 0));
                emit(r_type(FN_SUBU, 2, 14, 2, 0));
                emit(r_type(FN_XOR, 2, 15, 2, 0));
                emit(r_type(FN_ADDU, 2, 16, 2, 0));
                emit(r_type(FN_SLL, 0, 18, 21, 3));
                emit(r_type(FN_OR, 2, 21, 2, 0));
                emit(r_type(FN_SLL, 0, 20, 22, 5));
                emit(r_type(FN_ADDU, 2, 22, 2, 0));
                emit(r_type(FN_ADDU, 2, 19, 2, 0));
                emit_halt();
        endtask

        task automatic build_memory_program();
                prog_len = 0;
                emit(i_type(OP_ADDIU, 0, 8, 'h0100));
                emit(i_type(OP_ADDIU, 0, 9, 11));
                emit(i_type(OP_ADDIU, 0, 10, 22));
                emit(i_type(OP_ADDIU, 0, 11, 33));
                emit(i_type(OP_ADDIU, 0, 12, 44));
                emit(i_type(OP_SW, 8, 9, 0));
                emit(i_type(OP_SW, 8, 10, 4));
                emit(i_type(OP_SW, 8, 11, 8));
                emit(i_type(OP_SW, 8, 12, 12));
                emit(i_type(OP_SW, 8, 12, 4 + DATA_WORDS * 4));    // Aliases base+4.
                emit(i_type(OP_LW, 8, 13, 12));
                emit(i_type(OP_LW, 8, 14, 0));
                emit(i_type(OP_LW, 8, 15, 8 + DATA_WORDS * 4));
                emit(i_type(OP_LW, 8, 16, 4));
                emit(r_type(FN_ADDU, 13, 14, 2, 0));
                emit(r_type(FN_ADDU, 2, 15, 2, 0));
                emit(r_type(FN_ADDU, 2, 16, 2, 0));
                emit_halt();
        endtask

        task automatic build_loop_program();
                prog_len = 0;
                emit(i_type(OP_ADDIU, 0, 2, 0));
                emit(i_type(OP_ADDIU, 0, 8, 10));
                emit(i_type(OP_ADDIU, 0, 9, 3));
                emit(r_type(FN_ADDU, 2, 9, 2, 0));      // Loop body at index 3.
                emit(i_type(OP_ADDIU, 8, 8, -1));
                emit(i_type(OP_BNE, 8, 0, -3));
                emit(i_type(OP_ADDIU, 9, 9, 2));
                emit(i_type(OP_LUI, 0, 31, 'hBFC0));
                emit(i_type(OP_ADDIU, 31, 31, 12 * 4)); // Return to index 12.
                emit(j_type(15));
                emit(i_type(OP_ADDIU, 2, 2, 100));
                emit(i_type(OP_ADDIU, 2, 2, 5000));
                emit(i_type(OP_ADDIU, 2, 2, 7));
                emit_halt();
                emit(r_type(FN_SLL, 0, 2, 10, 1));      // Subroutine at index 15.
                emit(r_type(FN_JR, 31, 0, 0, 0));
                emit(r_type(FN_ADDU, 2, 10, 2, 0));
        endtask

        task automatic build_random_program();
                int k, sel, rd, rs, rt;
                prog_len = 0;
                for (k = 1; k <= 7; k++)
                        emit(i_type(OP_ADDIU, 0, k, $random(seed)));
                repeat (16) begin
                        sel = {$random(seed)} % 11;
                        rd = 1 + {$random(seed)} % 7;
                        rs = 1 + {$random(seed)} % 7;
                        rt = 1 + {$random(seed)} % 7;
                        case (sel)
                        0: emit(r_type(FN_ADDU, rs, rt, rd, 0));
                        1: emit(r_type(FN_SUBU, rs, rt, rd, 0));
                        2: emit(r_type(FN_AND, rs, rt, rd, 0));
                        3: emit(r_type(FN_OR, rs, rt, rd, 0));
                        4: emit(r_type(FN_XOR, rs, rt, rd, 0));
                        5: emit(r_type(FN_SLT, rs, rt, rd, 0));
                        6: emit(r_type(FN_SLTU, rs, rt, rd, 0));
                        7: emit(r_type(FN_SLL, 0, rt, rd, {$random(seed)} % 32));
                        8: emit(r_type(FN_SRL, 0, rt, rd, {$random(seed)} % 32));
                        9: emit(i_type(OP_ADDIU, rs, rd, $random(seed)));
                        default: emit(i_type(OP_LUI, 0, rd, $random(seed)));
                        endcase
                end
                emit(r_type(FN_ADDU, 2, 7, 2, 0));
                emit_halt();
        endtask

        // ------------------------------
        // Run and check
        // ------------------------------
        task automatic run_program(input string name, input logic stall);
                int     start;
                integer rnd;
                @(posedge clk);
                #2;
                rst_n = 1'b0;
                expected_v0 = model_run();
                start = halt_count;
                repeat (10) @(posedge clk);
                #2;
                rst_n = 1'b1;
                armed = 1'b1;
                while (halt_count == start) begin
                        @(posedge clk);
                        #2;
                        if (stall) begin
                                rnd = $random(seed);
                                clk_enable = rnd[0];    // Low about half the time.
                        end
                end
                armed = 1'b0;
                clk_enable = 1'b1;
                $display("%s: v0 = %h", name, register_v0);
        endtask

        task automatic check_halted_state();
                repeat (20) begin
                        @(negedge clk);
                        if (instr_address !== '0) begin
                                $display("ERROR at %0t: instr_address expected %h actual %h",
                                         $time, 32'h0, instr_address);
                                check_errors++;
                        end
                        if (register_v0 !== expected_v0) begin
                                $display("ERROR at %0t: register_v0 expected %h actual %h",
                                         $time, expected_v0, register_v0);
                                check_errors++;
                        end
                        if (active !== 1'b0) begin
                                $display("ERROR at %0t: active expected 0 actual %b",
                                         $time, active);
                                check_errors++;
                        end
                end
        endtask

        // Halt compare sampled at the falling edge.
        always @(negedge clk) begin
                if (!armed) begin
                        seen = 1'b0;
                end else if (!active && !seen) begin
                        if (register_v0 !== expected_v0) begin
                                $display("ERROR at %0t: register_v0 expected %h actual %h",
                                         $time, expected_v0, register_v0);
                                compare_errors++;
                        end
                        seen = 1'b1;
                        halt_count++;
                end
        end

        initial begin
                cycle_count = 0;
                while (cycle_count < MAX_CYCLES) begin
                        @(posedge clk);
                        cycle_count++;
                end
                $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
                $display("Test failed");
                $finish;
        end

        initial begin
                int n;
                rst_n = 1'b0;
                clk_enable = 1'b1;
                armed = 1'b0;
                expected_v0 = '0;
                build_sign_program();
                run_program("sign branches", 1'b0);
                if (register_v0 !== 32'd128) begin
                        $display("ERROR at %0t: register_v0 expected %h actual %h",
                                 $time, 32'd128, register_v0);
                        check_errors++;
                end
                build_alu_program();
                run_program("arithmetic and logic", 1'b0);
                build_memory_program();
                run_program("memory", 1'b0);
                build_loop_program();
                run_program("loops and jumps", 1'b0);
                check_halted_state();
                run_program("loops and jumps with stalls", 1'b1);
                check_halted_state();
                for (n = 0; n < 4; n++) begin
                        build_random_program();
                        run_program("random program", 1'b0);
                end
                $display("Errors: %0d in v0 compares, %0d in other checks",
                         compare_errors, check_errors);
                if (compare_errors + check_errors == 0)
                        $display("Test completed successfully");
                else
                        $display("Test failed");
                $finish;
        end

endmodule

`default_nettype wire

//--- all.f
+incdir+verification
verilog/mips_pkg.sv
verilog/mips_decoder.sv
verilog/mips_alu.sv
verilog/mips_regfile.sv
verilog/mips_cpu_harvard.sv
verilog/data_memory.sv
verilog/mips_system.sv
verification/tb_mips_system.sv

//--- run.sh
#!/bin/sh
# Builds and runs the MIPS system testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_mips_system -f all.f
./obj_dir/Vtb_mips_system | tee sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
